//--- flist.f
verilog/exe_cfg_pkg.sv
verilog/exe_isa_pkg.sv
verilog/exe_dispatch.sv
verilog/exe_alu_unit.sv
verilog/exe_sfu_unit.sv
verilog/exe_commit_arb.sv
verilog/exe_execute.sv
tests/tb_execute.sv

//--- run_sim.sh
#!/bin/sh
# builds the execute stage testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_execute -Mdir obj_dir -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_execute)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- tests/tb_execute.sv
// tb_execute drives directed instruction sequences into the execute stage and checks each result
`timescale 1ns/1ps

module tb_execute import exe_cfg_pkg::*, exe_isa_pkg::*; ();

    localparam int num_tests_c       = 5;
    localparam int cycles_per_test_c = 2000;

    // one pending commit together with the cycle on which it is due
    typedef struct {
        commit_t c;
        int      due;
        logic    timed;
        logic    cycle_read;
    } exp_commit_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        dispatch_valid;
    dispatch_t   dispatch_data;
    logic        dispatch_ready;
    logic        commit_valid;
    commit_t     commit_data;
    logic        commit_ready;
    logic        branch_ctl_valid;
    branch_ctl_t branch_ctl_data;
    logic        warp_ctl_valid;
    warp_ctl_t   warp_ctl_data;
    logic        sim_ebreak;

    exp_commit_t alu_q[$];
    exp_commit_t sfu_q[$];
    branch_ctl_t br_q[$];
    int          br_due[$];
    warp_ctl_t   wc_q[$];
    int          wc_due[$];
    word_t       cyc_val[$];
    int          cyc_acc[$];

    int   cyc = 0;
    int   rst_done_cyc = 0;
    int   errors = 0;
    int   tests_ok = 0;
    int   tests_bad = 0;
    int   accepts = 0;
    int   ebreak_seen = 0;
    pc_t  next_pc = 32'h0000_1000;
    logic check_latency;

    exe_execute #(
        .NUM_LANES (num_lanes_c),
        .NUM_WARPS (num_warps_c)
    ) UUT (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid   (dispatch_valid),
        .dispatch_data    (dispatch_data),
        .dispatch_ready   (dispatch_ready),
        .commit_valid     (commit_valid),
        .commit_data      (commit_data),
        .commit_ready     (commit_ready),
        .branch_ctl_valid (branch_ctl_valid),
        .branch_ctl_data  (branch_ctl_data),
        .warp_ctl_valid   (warp_ctl_valid),
        .warp_ctl_data    (warp_ctl_data),
        .sim_ebreak       (sim_ebreak)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string text);
        errors++;
        $display("ERROR t=%0t %s", $time, text);
    endtask

    function automatic int first_lane(input tmask_t m);
        int lane;
        lane = -1;
        for (int k = 0; k < num_lanes_c; k++) begin
            if (m[k] && lane < 0) lane = k;
        end
        return (lane < 0) ? 0 : lane;
    endfunction

    // integer results as the ISA defines them, one lane at a time
    function automatic word_t expect_alu(input logic [3:0] op, input word_t a, input word_t b,
                                         input pc_t pc);
        word_t r;
        case (op)
            alu_add: r = a + b;
            alu_sub: r = a - b;
            alu_and: r = a & b;
            alu_or:  r = a | b;
            alu_xor: r = a ^ b;
            alu_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sll: r = a << b[4:0];
            alu_srl: r = a >> b[4:0];
            alu_jal: r = pc + 32'd4;
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic commit_t expect_commit(input dispatch_t d);
        commit_t c;
        c.wid   = d.wid;
        c.tmask = d.tmask;
        c.pc    = d.pc;
        c.rd    = d.rd;
        c.wb    = d.wb;
        c.data  = '0;
        if (d.unit == unit_alu) begin
            if (d.op == alu_ebreak) c.wb = 1'b0;
            for (int k = 0; k < num_lanes_c; k++) begin
                if (d.tmask[k]) c.data[k] = expect_alu(d.op, d.rs1[k], d.rs2[k], d.pc);
            end
        end else if (d.op[1:0] == sfu_tmc) begin
            c.wb = 1'b0;
        end else begin
            for (int k = 0; k < num_lanes_c; k++) begin
                if (d.tmask[k]) c.data[k] = (d.csr == csr_warp_id) ? word_t'(d.wid) : word_t'(k);
            end
        end
        return c;
    endfunction

    function automatic branch_ctl_t expect_branch(input dispatch_t d);
        branch_ctl_t b;
        int          l;
        word_t       a;
        word_t       c;
        l     = first_lane(d.tmask);
        a     = d.rs1[l];
        c     = d.rs2[l];
        b.wid = d.wid;
        case (d.op)
            alu_beq: b.taken = (a == c);
            alu_bne: b.taken = (a != c);
            alu_blt: b.taken = ($signed(a) < $signed(c));
            default: b.taken = 1'b1;
        endcase
        b.dest = b.taken ? d.pc + d.imm : d.pc + 32'd4;
        return b;
    endfunction

    function automatic dispatch_t build_instr(input ex_unit_t unit, input logic [3:0] op,
                                              input warp_id_t wid, input tmask_t tmask);
        dispatch_t d;
        d       = '0;
        d.wid   = wid;
        d.tmask = tmask;
        d.pc    = next_pc;
        d.unit  = unit;
        d.op    = op;
        d.rd    = 5'($urandom_range(31, 1));
        d.wb    = 1'b1;
        d.imm   = $urandom_range(64, 1) * 4;
        for (int k = 0; k < num_lanes_c; k++) begin
            d.rs1[k] = $urandom;
            d.rs2[k] = $urandom;
        end
        // unique pcs let the monitor tell the two units' results apart
        next_pc = next_pc + 32'd4;
        return d;
    endfunction

    task automatic record_accept(input dispatch_t d);
        exp_commit_t e;
        warp_ctl_t   w;
        e.c          = expect_commit(d);
        e.due        = cyc + 2;
        e.timed      = check_latency;
        e.cycle_read = (d.unit == unit_sfu) && (d.op[1:0] == sfu_csr_read)
                    && (d.csr == csr_cycle);
        // the counter starts at zero on the first cycle out of reset and counts every clock
        if (e.cycle_read) begin
            for (int k = 0; k < num_lanes_c; k++) begin
                if (d.tmask[k]) e.c.data[k] = word_t'(cyc - rst_done_cyc);
            end
        end
        accepts++;
        if (d.unit == unit_alu) alu_q.push_back(e);
        else sfu_q.push_back(e);
        if (d.unit == unit_alu && d.op inside {alu_beq, alu_bne, alu_blt, alu_jal}) begin
            br_q.push_back(expect_branch(d));
            br_due.push_back(cyc + 1);
        end
        if (d.unit == unit_sfu && d.op[1:0] == sfu_tmc) begin
            w.wid   = d.wid;
            w.tmask = tmask_t'(d.rs1[first_lane(d.tmask)]);
            wc_q.push_back(w);
            wc_due.push_back(cyc + 1);
        end
    endtask

    // a commit must be the oldest pending result of one of the two units
    task automatic match_commit();
        exp_commit_t e;
        logic        found;
        found = 1'b1;
        if (alu_q.size() > 0 && alu_q[0].c.pc == commit_data.pc) e = alu_q.pop_front();
        else if (sfu_q.size() > 0 && sfu_q[0].c.pc == commit_data.pc) e = sfu_q.pop_front();
        else found = 1'b0;
        if (!found) begin
            report_error($sformatf("commit at pc %h is not the next result of either unit",
                                   commit_data.pc));
        end else begin
            check_value("commit_data.wid", 128'(commit_data.wid), 128'(e.c.wid));
            check_value("commit_data.tmask", 128'(commit_data.tmask), 128'(e.c.tmask));
            check_value("commit_data.rd", 128'(commit_data.rd), 128'(e.c.rd));
            check_value("commit_data.wb", 128'(commit_data.wb), 128'(e.c.wb));
            check_value("commit_data.data", 128'(commit_data.data), 128'(e.c.data));
            if (e.cycle_read) begin
                cyc_val.push_back(commit_data.data[0]);
                cyc_acc.push_back(e.due - 2);
            end
            if (e.timed) check_value("commit cycle", 128'(cyc), 128'(e.due));
        end
    endtask

    task automatic observe_cycle();
        logic        eb_exp;
        branch_ctl_t b;
        warp_ctl_t   w;
        eb_exp = dispatch_valid && dispatch_ready && (dispatch_data.unit == unit_alu)
              && (dispatch_data.op == alu_ebreak) && (dispatch_data.wid == 2'd0);
        check_value("sim_ebreak", 128'(sim_ebreak), 128'(eb_exp));
        if (sim_ebreak) ebreak_seen++;
        if (dispatch_valid && dispatch_ready) record_accept(dispatch_data);
        if (branch_ctl_valid) begin
            if (br_q.size() == 0) begin
                report_error("branch_ctl pulsed with no branch pending");
            end else begin
                b = br_q.pop_front();
                check_value("branch_ctl_data.wid", 128'(branch_ctl_data.wid), 128'(b.wid));
                check_value("branch_ctl_data.taken", 128'(branch_ctl_data.taken), 128'(b.taken));
                check_value("branch_ctl_data.dest", 128'(branch_ctl_data.dest), 128'(b.dest));
                check_value("branch_ctl cycle", 128'(cyc), 128'(br_due.pop_front()));
            end
        end else if (br_due.size() > 0 && br_due[0] <= cyc) begin
            report_error("branch_ctl pulse did not arrive one cycle after the branch");
            br_q.delete(0);
            br_due.delete(0);
        end
        if (warp_ctl_valid) begin
            if (wc_q.size() == 0) begin
                report_error("warp_ctl pulsed with no tmc pending");
            end else begin
                w = wc_q.pop_front();
                check_value("warp_ctl_data.wid", 128'(warp_ctl_data.wid), 128'(w.wid));
                check_value("warp_ctl_data.tmask", 128'(warp_ctl_data.tmask), 128'(w.tmask));
                check_value("warp_ctl cycle", 128'(cyc), 128'(wc_due.pop_front()));
            end
        end else if (wc_due.size() > 0 && wc_due[0] <= cyc) begin
            report_error("warp_ctl pulse did not arrive one cycle after the tmc");
            wc_q.delete(0);
            wc_due.delete(0);
        end
        if (commit_valid && commit_ready) match_commit();
    endtask

    // inputs change on the falling edge, so the middle of the low phase sees them settled
    always @(negedge clk) begin
        #5;
        if (!rst) observe_cycle();
    end

    task automatic send(input dispatch_t d);
        logic done;
        dispatch_data  = d;
        dispatch_valid = 1'b1;
        done           = 1'b0;
        while (!done) begin
            #5;
            done = dispatch_ready;
            @(negedge clk);
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((alu_q.size() + sfu_q.size() + br_q.size() + wc_q.size()) != 0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if ((alu_q.size() + sfu_q.size() + br_q.size() + wc_q.size()) != 0) begin
            report_error("pending results did not drain within 50 cycles");
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic exercise_alu_ops();
        int        errs;
        dispatch_t d;
        errs          = errors;
        check_latency = 1'b1;
        for (int op = 0; op < 8; op++) begin
            for (int rep = 0; rep < 3; rep++) begin
                d = build_instr(unit_alu, 4'(op), warp_id_t'($urandom_range(3, 0)),
                                tmask_t'($urandom_range(15, 1)));
                send(d);
                wait_idle();
            end
        end
        finish_test("alu_arith", errs);
    endtask

    task automatic resolve_branches();
        int        errs;
        int        lead;
        alu_op_t   ops [4];
        dispatch_t d;
        errs   = errors;
        ops[0] = alu_beq;
        ops[1] = alu_bne;
        ops[2] = alu_blt;
        ops[3] = alu_jal;
        for (int k = 0; k < 4; k++) begin
            for (int v = 0; v < 2; v++) begin
                d    = build_instr(unit_alu, ops[k], 2'(k), (v == 0) ? 4'b1100 : 4'b0110);
                lead = first_lane(d.tmask);
                // equal operands in the lead lane flip the outcome of beq and bne
                if (v == 0) d.rs2[lead] = d.rs1[lead];
                send(d);
                wait_idle();
            end
        end
        finish_test("branches", errs);
    endtask

    task automatic sfu_mask_and_csr();
        int        errs;
        dispatch_t d;
        errs = errors;
        d = build_instr(unit_sfu, 4'(sfu_tmc), 2'd1, 4'b0110);
        d.rs1[first_lane(d.tmask)] = word_t'($urandom_range(15, 1));
        send(d);
        wait_idle();
        d     = build_instr(unit_sfu, 4'(sfu_csr_read), 2'd2, 4'b1111);
        d.csr = csr_warp_id;
        send(d);
        wait_idle();
        d     = build_instr(unit_sfu, 4'(sfu_csr_read), 2'd3, 4'b1011);
        d.csr = csr_lane_id;
        send(d);
        wait_idle();
        cyc_val.delete();
        cyc_acc.delete();
        d     = build_instr(unit_sfu, 4'(sfu_csr_read), 2'd0, 4'b1111);
        d.csr = csr_cycle;
        send(d);
        repeat (6) @(negedge clk);
        d     = build_instr(unit_sfu, 4'(sfu_csr_read), 2'd0, 4'b1111);
        d.csr = csr_cycle;
        send(d);
        wait_idle();
        if (cyc_val.size() != 2) begin
            report_error("the two cycle counter reads did not both commit");
        end else begin
            check_value("cycle count difference", 128'(cyc_val[1] - cyc_val[0]),
                        128'(cyc_acc[1] - cyc_acc[0]));
        end
        finish_test("sfu", errs);
    endtask

    task automatic stall_commit();
        int errs;
        errs          = errors;
        check_latency = 1'b0;
        commit_ready  = 1'b0;
        accepts       = 0;
        fork
            begin
                dispatch_t bp_d;
                for (int i = 0; i < 6; i++) begin
                    if (i % 2 == 0) begin
                        bp_d = build_instr(unit_alu, alu_add, 2'd0, 4'b1111);
                    end else begin
                        bp_d     = build_instr(unit_sfu, 4'(sfu_csr_read), 2'd1, 4'b1111);
                        bp_d.csr = csr_lane_id;
                    end
                    send(bp_d);
                end
            end
            begin
                repeat (12) @(negedge clk);
                if (accepts > 3) report_error("more than three instructions taken while stalled");
                if (accepts == 0) report_error("no instruction taken while commit was stalled");
                commit_ready = 1'b1;
            end
        join
        wait_idle();
        check_latency = 1'b1;
        finish_test("backpressure", errs);
    endtask

    task automatic ebreak_stop();
        int        errs;
        dispatch_t d;
        errs        = errors;
        ebreak_seen = 0;
        d = build_instr(unit_alu, alu_ebreak, 2'd0, 4'b1111);
        send(d);
        wait_idle();
        d = build_instr(unit_alu, alu_ebreak, 2'd3, 4'b1111);
        send(d);
        wait_idle();
        if (ebreak_seen != 1) report_error("sim_ebreak was not raised once for the warp 0 ebreak");
        finish_test("ebreak", errs);
    endtask

    initial begin
        repeat (num_tests_c * cycles_per_test_c) @(posedge clk);
        $display("ERROR watchdog expired after %0d cycles", num_tests_c * cycles_per_test_c);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h81fc8604));
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_data  = '0;
        commit_ready   = 1'b1;
        check_latency  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst          = 1'b0;
        rst_done_cyc = cyc;
        if (commit_valid || branch_ctl_valid || warp_ctl_valid || sim_ebreak) begin
            report_error("outputs were not idle after reset");
        end
        exercise_alu_ops();
        resolve_branches();
        sfu_mask_and_csr();
        stall_commit();
        ebreak_stop();
        $display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog/exe_execute.sv
// exe_execute is the SIMT execute stage that ties dispatch, ALU, SFU and commit together
`timescale 1ns/1ps

module exe_execute import exe_cfg_pkg::*, exe_isa_pkg::*; #(
    parameter int NUM_LANES = num_lanes_c,
    parameter int NUM_WARPS = num_warps_c
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        dispatch_valid,
    input  dispatch_t   dispatch_data,
    output logic        dispatch_ready,

    output logic        commit_valid,
    output commit_t     commit_data,
    input  logic        commit_ready,

    output logic        branch_ctl_valid,
    output branch_ctl_t branch_ctl_data,

    output logic        warp_ctl_valid,
    output warp_ctl_t   warp_ctl_data,

    output logic        sim_ebreak
);

    logic      alu_req_valid;
    dispatch_t alu_req_data;
    logic      alu_req_ready;
    logic      sfu_req_valid;
    dispatch_t sfu_req_data;
    logic      sfu_req_ready;

    logic      alu_rsp_valid;
    commit_t   alu_rsp_data;
    logic      alu_rsp_ready;
    logic      sfu_rsp_valid;
    commit_t   sfu_rsp_data;
    logic      sfu_rsp_ready;

    exe_dispatch dispatch (
        .dispatch_valid (dispatch_valid),
        .dispatch_data  (dispatch_data),
        .dispatch_ready (dispatch_ready),
        .alu_valid      (alu_req_valid),
        .alu_data       (alu_req_data),
        .alu_ready      (alu_req_ready),
        .sfu_valid      (sfu_req_valid),
        .sfu_data       (sfu_req_data),
        .sfu_ready      (sfu_req_ready),
        .sim_ebreak     (sim_ebreak)
    );

    exe_alu_unit #(
        .NUM_LANES (NUM_LANES)
    ) alu_unit (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (alu_req_valid),
        .in_data          (alu_req_data),
        .in_ready         (alu_req_ready),
        .out_valid        (alu_rsp_valid),
        .out_data         (alu_rsp_data),
        .out_ready        (alu_rsp_ready),
        .branch_ctl_valid (branch_ctl_valid),
        .branch_ctl_data  (branch_ctl_data)
    );

    exe_sfu_unit #(
        .NUM_LANES (NUM_LANES),
        .NUM_WARPS (NUM_WARPS)
    ) sfu_unit (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (sfu_req_valid),
        .in_data        (sfu_req_data),
        .in_ready       (sfu_req_ready),
        .out_valid      (sfu_rsp_valid),
        .out_data       (sfu_rsp_data),
        .out_ready      (sfu_rsp_ready),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl_data  (warp_ctl_data)
    );

    exe_commit_arb commit_arb (
        .clk          (clk),
        .rst          (rst),
        .alu_valid    (alu_rsp_valid),
        .alu_data     (alu_rsp_data),
        .alu_ready    (alu_rsp_ready),
        .sfu_valid    (sfu_rsp_valid),
        .sfu_data     (sfu_rsp_data),
        .sfu_ready    (sfu_rsp_ready),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

endmodule

//--- verilog/exe_commit_arb.sv
// exe_commit_arb merges ALU and SFU results round-robin into one registered commit port
`timescale 1ns/1ps

module exe_commit_arb import exe_isa_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    alu_valid,
    input  commit_t alu_data,
    output logic    alu_ready,

    input  logic    sfu_valid,
    input  commit_t sfu_data,
    output logic    sfu_ready,

    output logic    commit_valid,
    output commit_t commit_data,
    input  logic    commit_ready
);

    // set when the SFU wins a tie
    logic sfu_first;
    logic can_load;
    logic grant_alu;
    logic grant_sfu;

    // the commit register accepts a new entry while empty or draining
    assign can_load = !commit_valid || commit_ready;

    assign grant_alu = can_load && alu_valid && (!sfu_valid || !sfu_first);
    assign grant_sfu = can_load && sfu_valid && (!alu_valid || sfu_first);

    assign alu_ready = grant_alu;
    assign sfu_ready = grant_sfu;

    always_ff @(posedge clk) begin
        if (rst) begin
            sfu_first    <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            // the winner drops to the back for the next contest
            if (grant_alu) begin
                sfu_first <= 1'b1;
            end else if (grant_sfu) begin
                sfu_first <= 1'b0;
            end

            if (grant_alu || grant_sfu) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_alu) begin
            commit_data <= alu_data;
        end else if (grant_sfu) begin
            commit_data <= sfu_data;
        end
    end

endmodule

//--- verilog/exe_sfu_unit.sv
// exe_sfu_unit handles thread-mask control and CSR reads for the execute stage
`timescale 1ns/1ps

module exe_sfu_unit import exe_cfg_pkg::*, exe_isa_pkg::*; #(
    parameter int NUM_LANES = num_lanes_c,
    parameter int NUM_WARPS = num_warps_c
) (
    input  logic      clk,
    input  logic      rst,

    input  logic      in_valid,
    input  dispatch_t in_data,
    output logic      in_ready,

    output logic      out_valid,
    output commit_t   out_data,
    input  logic      out_ready,

    output logic      warp_ctl_valid,
    output warp_ctl_t warp_ctl_data
);

    localparam int wid_bits = $clog2(NUM_WARPS);

    word_t                   cycle_q;
    word_t [num_lanes_c-1:0] lane_res;
    logic                    is_tmc;
    tmask_t                  new_tmask;
    logic                    in_fire;

    assign is_tmc    = (sfu_op_t'(in_data.op[1:0]) == sfu_tmc);
    assign new_tmask = tmask_t'(in_data.rs1[lead_lane(in_data.tmask)]);

    // tmc returns no data, so only CSR reads fill the active lanes
    always_comb begin
        lane_res = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (in_data.tmask[i] && !is_tmc) begin
                case (in_data.csr)
                    csr_warp_id: lane_res[i] = word_t'(in_data.wid[wid_bits-1:0]);
                    csr_lane_id: lane_res[i] = word_t'(i);
                    default:     lane_res[i] = cycle_q;
                endcase
            end
        end
    end

    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_q        <= '0;
            out_valid      <= 1'b0;
            warp_ctl_valid <= 1'b0;
        end else begin
            cycle_q <= cycle_q + word_t'(1);
            if (in_fire) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            warp_ctl_valid <= in_fire && is_tmc;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data.wid        <= in_data.wid;
            out_data.tmask      <= in_data.tmask;
            out_data.pc         <= in_data.pc;
            out_data.rd         <= in_data.rd;
            out_data.wb         <= in_data.wb && !is_tmc;
            out_data.data       <= lane_res;
            warp_ctl_data.wid   <= in_data.wid;
            warp_ctl_data.tmask <= new_tmask;
        end
    end

endmodule

//--- verilog/exe_alu_unit.sv
// exe_alu_unit runs integer operations on every active lane and resolves branches
`timescale 1ns/1ps

module exe_alu_unit import exe_cfg_pkg::*, exe_isa_pkg::*; #(
    parameter int NUM_LANES = num_lanes_c
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        in_valid,
    input  dispatch_t   in_data,
    output logic        in_ready,

    output logic        out_valid,
    output commit_t     out_data,
    input  logic        out_ready,

    output logic        branch_ctl_valid,
    output branch_ctl_t branch_ctl_data
);

    localparam int shamt_bits = $clog2(xlen_c);

    alu_op_t                 alu_op;
    word_t [num_lanes_c-1:0] lane_res;
    lane_idx_t               lead;
    logic                    is_branch;
    logic                    taken;
    pc_t                     br_dest;
    logic                    in_fire;

    function automatic word_t alu_calc(input alu_op_t op, input word_t a, input word_t b,
                                       input pc_t pc);
        word_t res;
        case (op)
            alu_add: res = a + b;
            alu_sub: res = a - b;
            alu_and: res = a & b;
            alu_or:  res = a | b;
            alu_xor: res = a ^ b;
            alu_slt: res = word_t'($signed(a) < $signed(b));
            alu_sll: res = a << b[shamt_bits-1:0];
            alu_srl: res = a >> b[shamt_bits-1:0];
            // jal links the return address
            alu_jal: res = pc + pc_t'(4);
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic logic br_taken(input alu_op_t op, input word_t a, input word_t b);
        logic res;
        case (op)
            alu_beq: res = (a == b);
            alu_bne: res = (a != b);
            alu_blt: res = ($signed(a) < $signed(b));
            alu_jal: res = 1'b1;
            default: res = 1'b0;
        endcase
        return res;
    endfunction

    assign alu_op = alu_op_t'(in_data.op);

    // lanes with a clear tmask bit commit zero
    always_comb begin
        lane_res = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (in_data.tmask[i]) begin
                lane_res[i] = alu_calc(alu_op, in_data.rs1[i], in_data.rs2[i], in_data.pc);
            end
        end
    end

    assign lead      = lead_lane(in_data.tmask);
    assign is_branch = alu_op inside {alu_beq, alu_bne, alu_blt, alu_jal};
    assign taken     = br_taken(alu_op, in_data.rs1[lead], in_data.rs2[lead]);
    assign br_dest   = taken ? (in_data.pc + in_data.imm) : (in_data.pc + pc_t'(4));

    // the output register can take a new result while empty or draining
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid        <= 1'b0;
            branch_ctl_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            // the branch pulse goes out with the register load, whatever the commit side does
            branch_ctl_valid <= in_fire && is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data.wid         <= in_data.wid;
            out_data.tmask       <= in_data.tmask;
            out_data.pc          <= in_data.pc;
            out_data.rd          <= in_data.rd;
            out_data.wb          <= in_data.wb && (alu_op != alu_ebreak);
            out_data.data        <= lane_res;
            branch_ctl_data.wid   <= in_data.wid;
            branch_ctl_data.taken <= taken;
            branch_ctl_data.dest  <= br_dest;
        end
    end

endmodule

//--- verilog/exe_dispatch.sv
// exe_dispatch steers each dispatched instruction to the ALU or the SFU and flags ebreak
`timescale 1ns/1ps

module exe_dispatch import exe_isa_pkg::*; (
    input  logic      dispatch_valid,
    input  dispatch_t dispatch_data,
    output logic      dispatch_ready,

    output logic      alu_valid,
    output dispatch_t alu_data,
    input  logic      alu_ready,

    output logic      sfu_valid,
    output dispatch_t sfu_data,
    input  logic      sfu_ready,

    // simulation helper that marks the end of a test program
    output logic      sim_ebreak
);

    logic to_alu;
    logic is_ebreak;

    assign to_alu = (dispatch_data.unit == unit_alu);

    // only the selected unit sees a valid request
    assign alu_valid = dispatch_valid && to_alu;
    assign sfu_valid = dispatch_valid && !to_alu;

    // both units get the same payload and ignore it while their valid is low
    assign alu_data = dispatch_data;
    assign sfu_data = dispatch_data;

    // the instruction is accepted when its own unit can take it
    assign dispatch_ready = to_alu ? alu_ready : sfu_ready;

    assign is_ebreak = to_alu && (alu_op_t'(dispatch_data.op) == alu_ebreak);

    // warp 0 hitting ebreak ends the program
    assign sim_ebreak = dispatch_valid && dispatch_ready && is_ebreak
                     && (dispatch_data.wid == '0);

endmodule

//--- verilog/exe_isa_pkg.sv
// exe_isa_pkg defines the unit and operation encodings and the buses of the execute stage
package exe_isa_pkg;
    import exe_cfg_pkg::*;

    typedef logic [0:0] ex_unit_t;
    localparam ex_unit_t unit_alu = 1'b0;
    localparam ex_unit_t unit_sfu = 1'b1;

    typedef logic [3:0] alu_op_t;
    localparam alu_op_t alu_add    = 4'h0;
    localparam alu_op_t alu_sub    = 4'h1;
    localparam alu_op_t alu_and    = 4'h2;
    localparam alu_op_t alu_or     = 4'h3;
    localparam alu_op_t alu_xor    = 4'h4;
    localparam alu_op_t alu_slt    = 4'h5;
    localparam alu_op_t alu_sll    = 4'h6;
    localparam alu_op_t alu_srl    = 4'h7;
    localparam alu_op_t alu_beq    = 4'h8;
    localparam alu_op_t alu_bne    = 4'h9;
    localparam alu_op_t alu_blt    = 4'ha;
    localparam alu_op_t alu_jal    = 4'hb;
    localparam alu_op_t alu_ebreak = 4'hc;

    typedef logic [1:0] sfu_op_t;
    localparam sfu_op_t sfu_tmc      = 2'd0;
    localparam sfu_op_t sfu_csr_read = 2'd1;

    typedef logic [1:0] csr_addr_t;
    localparam csr_addr_t csr_warp_id = 2'd0;
    localparam csr_addr_t csr_lane_id = 2'd1;
    localparam csr_addr_t csr_cycle   = 2'd2;

    // op is shared by both units and each one reads it as its own op type
    typedef struct packed {
        warp_id_t                 wid;
        tmask_t                   tmask;
        pc_t                      pc;
        ex_unit_t                 unit;
        logic [3:0]               op;
        csr_addr_t                csr;
        logic [4:0]               rd;
        logic                     wb;
        word_t [num_lanes_c-1:0]  rs1;
        word_t [num_lanes_c-1:0]  rs2;
        word_t                    imm;
    } dispatch_t;

    typedef struct packed {
        warp_id_t                 wid;
        tmask_t                   tmask;
        pc_t                      pc;
        logic [4:0]               rd;
        logic                     wb;
        word_t [num_lanes_c-1:0]  data;
    } commit_t;

    typedef struct packed {
        warp_id_t wid;
        logic     taken;
        pc_t      dest;
    } branch_ctl_t;

    typedef struct packed {
        warp_id_t wid;
        tmask_t   tmask;
    } warp_ctl_t;

endpackage

//--- verilog/exe_cfg_pkg.sv
// exe_cfg_pkg holds the lane, warp and word widths of the execute stage
package exe_cfg_pkg;

    // the top-level NUM_LANES and NUM_WARPS parameters start from these counts
    localparam int num_lanes_c = 4;
    localparam int num_warps_c = 4;

    localparam int xlen_c = 32;

    typedef logic [$clog2(num_lanes_c)-1:0] lane_idx_t;
    typedef logic [$clog2(num_warps_c)-1:0] warp_id_t;
    typedef logic [xlen_c-1:0]              word_t;
    typedef logic [xlen_c-1:0]              pc_t;
    typedef logic [num_lanes_c-1:0]         tmask_t;

    // branches and tmc take their operands from the lowest active lane
    function automatic lane_idx_t lead_lane(input tmask_t tmask);
        lane_idx_t lead;
        lead = '0;
        for (int i = num_lanes_c - 1; i >= 0; i--) begin
            if (tmask[i]) lead = lane_idx_t'(i);
        end
        return lead;
    endfunction

endpackage
